//--- hw/cache_pkg.sv
package cache_pkg;

  // Sizes, all written around a two-way organisation
  localparam int DATA_W    = 32;
  localparam int ADDR_W    = 12;
  localparam int INDEX_W   = 4;
  localparam int SETS      = 16;
  localparam int TAG_W     = 8;
  localparam int NUM_PORTS = 2;
  localparam int PORT_W    = 1;

  typedef enum logic [2:0] {
    IDLE,
    CHECK,
    WRITEBACK,
    FETCH,
    FETCH_WAIT
  } ctrl_state_t;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } mem_op_t;

  // Requester side
  typedef struct packed {
    mem_op_t             op;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
  } cache_req_t;

  typedef struct packed {
    logic [DATA_W-1:0]   rdata;
    logic [PORT_W-1:0]   port;
  } cache_resp_t;

  // Memory side, flags held until resp
  typedef struct packed {
    logic                read;
    logic                write;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
  } mem_req_t;

  typedef struct packed {
    logic                resp;
    logic [DATA_W-1:0]   rdata;
  } mem_resp_t;

endpackage

//--- hw/l2_arbiter.sv
module l2_arbiter (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [cache_pkg::NUM_PORTS-1:0]     req_valid,
  input  cache_pkg::cache_req_t               req [cache_pkg::NUM_PORTS],
  input  logic                                idle,
  input  logic                                respond,
  output logic                                grant,
  output cache_pkg::cache_req_t               grant_req,
  output logic [cache_pkg::PORT_W-1:0]        grant_port,
  output logic [cache_pkg::NUM_PORTS-1:0]     resp_valid
);
  import cache_pkg::*;

  // One pending slot per port is enough with one request outstanding
  logic [NUM_PORTS-1:0] pending;
  cache_req_t           pend_req [NUM_PORTS];

  // Last granted port, doubles as the owner of the request in flight
  logic [PORT_W-1:0]    last_port;
  logic                 grant_q;
  logic [PORT_W-1:0]    sel;

  // Round robin between the two ports
  always_comb begin
    if (pending[0] && pending[1]) begin
      sel = ~last_port;
    end
    else if (pending[1]) begin
      sel = PORT_W'(1);
    end
    else begin
      sel = PORT_W'(0);
    end
  end

  assign grant      = idle && !grant_q && (|pending);
  assign grant_req  = pend_req[sel];
  assign grant_port = sel;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end
    else begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (grant && (sel == PORT_W'(p))) begin
          pending[p] <= 1'b0;
        end
        if (req_valid[p]) begin
          pending[p] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (req_valid[p]) begin
        pend_req[p] <= req[p];
      end
    end
  end

  // Response strobe goes to the port that owns the request
  always_ff @(posedge clk) begin
    if (rst) begin
      grant_q    <= 1'b0;
      last_port  <= '1;
      resp_valid <= '0;
    end
    else begin
      grant_q <= grant;
      if (grant) begin
        last_port <= sel;
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        resp_valid[p] <= respond && (last_port == PORT_W'(p));
      end
    end
  end

endmodule

//--- hw/l2_control.sv
module l2_control (
  input  logic clk,
  input  logic rst,

  // Arbiter
  input  logic grant,
  output logic idle,
  output logic respond,

  // Datapath
  input  logic hit,
  input  logic victim_dirty,
  input  logic is_write,
  output logic lookup,
  output logic write_from_cpu,
  output logic write_from_mem,

  // Memory port
  input  logic mem_resp_flag,
  output logic mem_read,
  output logic mem_write
);
  import cache_pkg::*;

  ctrl_state_t curr_state;
  ctrl_state_t next_state;

  assign idle = (curr_state == IDLE);

  always_comb begin
    next_state     = curr_state;
    lookup         = 1'b0;
    write_from_cpu = 1'b0;
    write_from_mem = 1'b0;
    respond        = 1'b0;
    mem_read       = 1'b0;
    mem_write      = 1'b0;

    unique case (curr_state)
      IDLE: begin
        if (grant) begin
          // Snapshot the set while the request is latched
          lookup     = 1'b1;
          next_state = CHECK;
        end
      end
      CHECK: begin
        if (hit) begin
          respond        = 1'b1;
          write_from_cpu = is_write;
          next_state     = IDLE;
        end
        else if (victim_dirty) begin
          next_state = WRITEBACK;
        end
        else begin
          next_state = FETCH;
        end
      end
      WRITEBACK: begin
        mem_write = 1'b1;
        if (mem_resp_flag) begin
          next_state = FETCH;
        end
      end
      FETCH: begin
        mem_read = 1'b1;
        if (mem_resp_flag) begin
          // Refill lands in the victim way at this edge
          write_from_mem = 1'b1;
          next_state     = FETCH_WAIT;
        end
      end
      FETCH_WAIT: begin
        // Re-read the refilled set, CHECK then hits
        lookup     = 1'b1;
        next_state = CHECK;
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      curr_state <= IDLE;
    end
    else begin
      curr_state <= next_state;
    end
  end

endmodule

//--- hw/l2_datapath.sv
module l2_datapath (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          grant,
  input  cache_pkg::cache_req_t         grant_req,
  input  logic [cache_pkg::PORT_W-1:0]  grant_port,
  input  logic                          lookup,
  input  logic                          write_from_cpu,
  input  logic                          write_from_mem,
  input  logic                          respond,
  input  cache_pkg::mem_resp_t          mem_resp,
  output logic                          hit,
  output logic                          victim_dirty,
  output logic                          is_write,
  output cache_pkg::mem_req_t           mem_addr_data,
  output cache_pkg::cache_resp_t        resp
);
  import cache_pkg::*;

  typedef struct packed {
    logic              valid;
    logic              dirty;
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] data;
  } line_t;

  // Two ways per set
  line_t             lines [2][SETS];
  logic [SETS-1:0]   lru;
  line_t             snap [2];
  logic              snap_lru;

  cache_req_t        req_q;
  logic [PORT_W-1:0] port_q;
  logic [INDEX_W-1:0] index;
  logic [INDEX_W-1:0] rd_index;
  logic [TAG_W-1:0]  tag;
  logic [1:0]        way_hit;
  logic              hit_way;
  logic              victim_way;

  assign index    = req_q.addr[INDEX_W-1:0];
  assign tag      = req_q.addr[ADDR_W-1:INDEX_W];
  // Lookup on grant uses the incoming address
  assign rd_index = grant ? grant_req.addr[INDEX_W-1:0] : index;

  always_ff @(posedge clk) begin
    if (grant) begin
      req_q  <= grant_req;
      port_q <= grant_port;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < 2; w++) begin
        snap[w].valid <= 1'b0;
        snap[w].dirty <= 1'b0;
      end
    end
    else if (lookup) begin
      snap[0]  <= lines[0][rd_index];
      snap[1]  <= lines[1][rd_index];
      snap_lru <= lru[rd_index];
    end
    else if (mem_resp.resp) begin
      // Victim is clean once written back, address switches to the fetch
      snap[victim_way].dirty <= 1'b0;
    end
  end

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = snap[w].valid && (snap[w].tag == tag);
    end
  end

  assign hit      = |way_hit;
  assign hit_way  = way_hit[1];
  assign is_write = (req_q.op == OP_WRITE);

  // Invalid way first, otherwise LRU
  always_comb begin
    if (!snap[0].valid) begin
      victim_way = 1'b0;
    end
    else if (!snap[1].valid) begin
      victim_way = 1'b1;
    end
    else begin
      victim_way = snap_lru;
    end
  end

  assign victim_dirty = snap[victim_way].valid && snap[victim_way].dirty;

  always_comb begin
    mem_addr_data.read  = 1'b0;
    mem_addr_data.write = 1'b0;
    mem_addr_data.wdata = snap[victim_way].data;
    if (victim_dirty) begin
      mem_addr_data.addr = {snap[victim_way].tag, index};
    end
    else begin
      mem_addr_data.addr = req_q.addr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < 2; w++) begin
        for (int s = 0; s < SETS; s++) begin
          lines[w][s].valid <= 1'b0;
          lines[w][s].dirty <= 1'b0;
        end
      end
      lru <= '0;
    end
    else begin
      if (write_from_cpu) begin
        lines[hit_way][index].data  <= req_q.wdata;
        lines[hit_way][index].dirty <= 1'b1;
      end
      if (write_from_mem) begin
        lines[victim_way][index] <= '{valid: 1'b1, dirty: 1'b0, tag: tag,
                                      data: mem_resp.rdata};
      end
      // LRU points at the way not just used
      if (respond) begin
        lru[index] <= ~hit_way;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (respond) begin
      resp.rdata <= is_write ? req_q.wdata : snap[hit_way].data;
      resp.port  <= port_q;
    end
  end

endmodule

//--- hw/l2_top.sv
module l2_top (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [cache_pkg::NUM_PORTS-1:0]    req_valid,
  input  cache_pkg::cache_req_t              req [cache_pkg::NUM_PORTS],
  output logic [cache_pkg::NUM_PORTS-1:0]    resp_valid,
  output cache_pkg::cache_resp_t             resp,
  output cache_pkg::mem_req_t                mem_req,
  input  cache_pkg::mem_resp_t               mem_resp
);
  import cache_pkg::*;

  logic              grant;
  cache_req_t        grant_req;
  logic [PORT_W-1:0] grant_port;
  logic              idle;
  logic              respond;
  logic              hit;
  logic              victim_dirty;
  logic              is_write;
  logic              lookup;
  logic              write_from_cpu;
  logic              write_from_mem;
  logic              mem_read;
  logic              mem_write;
  mem_req_t          mem_addr_data;

  // Flags from the controller, address and data from the datapath
  assign mem_req = '{read: mem_read, write: mem_write,
                     addr: mem_addr_data.addr, wdata: mem_addr_data.wdata};

  l2_arbiter l2_arbiter_i (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req        (req),
    .idle       (idle),
    .respond    (respond),
    .grant      (grant),
    .grant_req  (grant_req),
    .grant_port (grant_port),
    .resp_valid (resp_valid)
  );

  l2_control l2_control_i (
    .clk            (clk),
    .rst            (rst),
    .grant          (grant),
    .idle           (idle),
    .respond        (respond),
    .hit            (hit),
    .victim_dirty   (victim_dirty),
    .is_write       (is_write),
    .lookup         (lookup),
    .write_from_cpu (write_from_cpu),
    .write_from_mem (write_from_mem),
    .mem_resp_flag  (mem_resp.resp),
    .mem_read       (mem_read),
    .mem_write      (mem_write)
  );

  l2_datapath l2_datapath_i (
    .clk            (clk),
    .rst            (rst),
    .grant          (grant),
    .grant_req      (grant_req),
    .grant_port     (grant_port),
    .lookup         (lookup),
    .write_from_cpu (write_from_cpu),
    .write_from_mem (write_from_mem),
    .respond        (respond),
    .mem_resp       (mem_resp),
    .hit            (hit),
    .victim_dirty   (victim_dirty),
    .is_write       (is_write),
    .mem_addr_data  (mem_addr_data),
    .resp           (resp)
  );

endmodule

//--- dv/l2_asserts.sv
module l2_control_asserts (
  input logic                   clk,
  input logic                   rst,
  input cache_pkg::ctrl_state_t curr_state,
  input logic                   respond,
  input logic                   mem_read,
  input logic                   mem_write,
  input logic                   mem_resp_flag
);
  timeunit 1ns;
  timeprecision 1ps;
  import cache_pkg::*;

  assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
    else $error("memory read and write high together");

  assert property (@(posedge clk) disable iff (rst) respond |-> curr_state == CHECK)
    else $error("respond raised outside CHECK");

  assert property (@(posedge clk) disable iff (rst)
    curr_state inside {IDLE, CHECK, WRITEBACK, FETCH, FETCH_WAIT})
    else $error("controller state outside its encoding");

  // Memory flags are level requests held until the response
  assert property (@(posedge clk) disable iff (rst) mem_read && !mem_resp_flag |=> mem_read)
    else $error("memory read dropped before response");

  assert property (@(posedge clk) disable iff (rst) mem_write && !mem_resp_flag |=> mem_write)
    else $error("memory write dropped before response");

endmodule

//--- dv/l2_tb.sv
module l2_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import cache_pkg::*;

  localparam int NUM_REQ   = 2000;
  localparam int NUM_FLUSH = 32;
  localparam int TOTAL     = NUM_REQ + NUM_FLUSH;
  localparam int RANGE     = 48;
  localparam int MEM_WORDS = 1 << ADDR_W;

  logic                 clk = 1'b0;
  logic                 rst;
  logic [NUM_PORTS-1:0] req_valid;
  cache_req_t           req [NUM_PORTS];
  logic [NUM_PORTS-1:0] resp_valid;
  cache_resp_t          resp;
  mem_req_t             mem_req;
  mem_resp_t            mem_resp;

  integer     seed;
  int         cycle;
  int         issued;
  int         answered;
  int         last_port;
  int         mem_wait;
  logic       go;
  logic       outst [NUM_PORTS];
  cache_req_t open_req [NUM_PORTS];
  int         issue_cyc [NUM_PORTS];
  int         gap [NUM_PORTS];

  // Behavioral memory and the coherent value of every word
  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [DATA_W-1:0] coh [MEM_WORDS];
  mem_req_t          mreq_s;
  mem_req_t          mem_log [$];
  mem_req_t          exp_log [$];

  // Tag model for both ways
  logic             m_valid [2][SETS];
  logic             m_dirty [2][SETS];
  logic [TAG_W-1:0] m_tag [2][SETS];
  logic             m_lru [SETS];

  l2_top l2_top_i (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req        (req),
    .resp_valid (resp_valid),
    .resp       (resp),
    .mem_req    (mem_req),
    .mem_resp   (mem_resp)
  );

  bind l2_control l2_control_asserts l2_control_asserts_i (
    .clk           (clk),
    .rst           (rst),
    .curr_state    (curr_state),
    .respond       (respond),
    .mem_read      (mem_read),
    .mem_write     (mem_write),
    .mem_resp_flag (mem_resp_flag)
  );

  always #5 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_resp(input cache_resp_t got, input cache_resp_t want);
    if (got !== want) begin
      report_failure($sformatf("[FAIL] %0t resp: got rdata %h port %0d, expected rdata %h port %0d",
                               $time, got.rdata, got.port, want.rdata, want.port));
    end
  endtask

  task automatic check_mem_req(input mem_req_t got, input mem_req_t want);
    if (got !== want) begin
      report_failure($sformatf("[FAIL] %0t mem_req: got %b/%b %h %h, expected %b/%b %h %h",
                               $time, got.read, got.write, got.addr, got.wdata,
                               want.read, want.write, want.addr, want.wdata));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      report_failure($sformatf("[FAIL] %0t %s: got %b, expected %b", $time, name, got, want));
    end
  endtask

  // Predicts memory traffic and read data and updates the tag model
  task automatic model_access(input cache_req_t r, output logic [DATA_W-1:0] rdata);
    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   tg;
    logic [ADDR_W-1:0]  va;
    mem_req_t           e;
    int                 w;
    int                 v;
    idx = r.addr[INDEX_W-1:0];
    tg  = r.addr[ADDR_W-1:INDEX_W];
    w   = -1;
    for (int i = 0; i < 2; i++) begin
      if (m_valid[i][idx] && m_tag[i][idx] == tg) begin
        w = i;
      end
    end
    if (w < 0) begin
      if (!m_valid[0][idx]) begin
        v = 0;
      end
      else if (!m_valid[1][idx]) begin
        v = 1;
      end
      else begin
        v = int'(m_lru[idx]);
      end
      if (m_valid[v][idx] && m_dirty[v][idx]) begin
        va = {m_tag[v][idx], idx};
        e  = '{read: 1'b0, write: 1'b1, addr: va, wdata: coh[va]};
        exp_log.push_back(e);
      end
      e = '{read: 1'b1, write: 1'b0, addr: r.addr, wdata: '0};
      exp_log.push_back(e);
      m_valid[v][idx] = 1'b1;
      m_dirty[v][idx] = 1'b0;
      m_tag[v][idx]   = tg;
      w = v;
    end
    if (r.op == OP_WRITE) begin
      coh[r.addr]     = r.wdata;
      m_dirty[w][idx] = 1'b1;
    end
    rdata      = coh[r.addr];
    m_lru[idx] = (w == 0);
  endtask

  // Requesters and memory driven on the rising edge
  always @(posedge clk) begin
    cache_req_t r;
    mem_req_t   a;
    cycle = cycle + 1;
    req_valid <= '0;
    if (rst) begin
      mem_resp <= '0;
      mem_wait = -1;
    end
    else begin
      if (mem_resp.resp) begin
        mem_resp <= '0;
      end
      else if (mreq_s.read || mreq_s.write) begin
        if (mem_wait < 0) begin
          mem_wait = $unsigned($random(seed)) % 6;
        end
        if (mem_wait == 0) begin
          a = mreq_s;
          if (a.write) begin
            mem[a.addr] = a.wdata;
          end
          else begin
            a.wdata = '0;
          end
          mem_log.push_back(a);
          mem_resp <= '{resp: 1'b1, rdata: mem[a.addr]};
          mem_wait = -1;
        end
        else begin
          mem_wait--;
        end
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (go && !outst[p] && issued < TOTAL && (issued < NUM_REQ || answered >= NUM_REQ)) begin
          if (gap[p] > 0) begin
            gap[p]--;
          end
          else begin
            if (issued < NUM_REQ) begin
              r.op    = ($random(seed) & 1) ? OP_WRITE : OP_READ;
              r.addr  = ADDR_W'($unsigned($random(seed)) % RANGE);
              r.wdata = $random(seed);
            end
            else begin
              // Two new tags per set push every line out
              r.op    = OP_READ;
              r.addr  = ADDR_W'(RANGE + issued - NUM_REQ);
              r.wdata = '0;
            end
            req[p]       <= r;
            req_valid[p] <= 1'b1;
            outst[p]     = 1'b1;
            open_req[p]  = r;
            issue_cyc[p] = cycle;
            issued++;
            gap[p] = $unsigned($random(seed)) % 4;
          end
        end
      end
    end
  end

  // Monitor samples on the falling edge
  always @(negedge clk) begin
    cache_resp_t want;
    int          p;
    mreq_s = mem_req;
    if (!rst && go) begin
      for (int q = 0; q < NUM_PORTS; q++) begin
        if (outst[q] && cycle - issue_cyc[q] > 2000) begin
          report_failure($sformatf("Port %0d got no response to its request", q));
        end
      end
      if (resp_valid == 2'b11) begin
        report_failure("Both ports got a response in the same cycle");
      end
      else if (resp_valid != '0) begin
        p = resp_valid[1] ? 1 : 0;
        if (!outst[p]) begin
          report_failure($sformatf("Port %0d got a response with no request open", p));
        end
        // A port pending as long or longer must not lose to a repeat grant
        if (last_port == p && outst[1-p] && issue_cyc[1-p] <= issue_cyc[p]) begin
          report_failure($sformatf("Port %0d was granted twice while port %0d waited", p, 1 - p));
        end
        model_access(open_req[p], want.rdata);
        want.port = PORT_W'(p);
        check_resp(resp, want);
        if (mem_log.size() != exp_log.size()) begin
          report_failure($sformatf("Request saw %0d memory accesses, expected %0d",
                                   mem_log.size(), exp_log.size()));
        end
        for (int i = 0; i < exp_log.size(); i++) begin
          check_mem_req(mem_log[i], exp_log[i]);
        end
        mem_log.delete();
        exp_log.delete();
        outst[p]  = 1'b0;
        last_port = p;
        answered++;
      end
    end
  end

  initial begin
    logic [ADDR_W-1:0] fill;
    int                waited;
    seed       = 32'hc1c2;
    rst        = 1'b1;
    go         = 1'b0;
    req_valid  = '0;
    mem_resp   = '0;
    cycle      = 0;
    issued     = 0;
    answered   = 0;
    last_port  = -1;
    mem_wait   = -1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      req[p]    = '0;
      outst[p]  = 1'b0;
      gap[p]    = 0;
    end
    for (int a = 0; a < MEM_WORDS; a++) begin
      fill   = ADDR_W'(a);
      mem[a] = {fill, 8'h5a, ~fill};
      coh[a] = mem[a];
    end
    for (int s = 0; s < SETS; s++) begin
      m_lru[s] = 1'b0;
      for (int w = 0; w < 2; w++) begin
        m_valid[w][s] = 1'b0;
        m_dirty[w][s] = 1'b0;
        m_tag[w][s]   = '0;
      end
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // Quiet outputs before any request
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check_bit("resp_valid[0]", resp_valid[0], 1'b0);
      check_bit("resp_valid[1]", resp_valid[1], 1'b0);
      check_bit("mem_req.read", mem_req.read, 1'b0);
      check_bit("mem_req.write", mem_req.write, 1'b0);
    end
    go = 1'b1;
    waited = 0;
    while (answered < TOTAL) begin
      @(posedge clk);
      waited++;
      if (waited > 400000) begin
        report_failure("Timed out waiting for all responses");
      end
    end
    for (int a = 0; a < RANGE; a++) begin
      if (mem[a] !== coh[a]) begin
        report_failure($sformatf("[FAIL] %0t mem[%0d]: got %h, expected %h",
                                 $time, a, mem[a], coh[a]));
      end
    end
    $display("Verification passed");
    $finish;
  end

endmodule

//--- l2cache.f
hw/cache_pkg.sv
hw/l2_arbiter.sv
hw/l2_control.sv
hw/l2_datapath.sv
hw/l2_top.sv
dv/l2_asserts.sv
dv/l2_tb.sv

//--- Makefile
TOP = l2_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f l2cache.f -o sim_l2
	./obj_dir/sim_l2 | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
